/* list.f */
+incdir+source
source/rv_isa_pkg.sv
source/fe_pkg.sv
source/fetch_if.sv
source/fetch_buffer.sv
source/rvc_expander.sv
source/instr_aligner.sv
source/front_end_top.sv
verif/tb_clock_gen.sv
verif/front_end_props.sv
verif/front_end_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module front_end_tb

output=$(./obj_dir/Vfront_end_tb) || { printf '%s\n' "$output"; exit 1; }
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx 'PASS: all tests'

/* verif/front_end_tb.sv */
`timescale 1ns/1ps

`include "fe_config.svh"

module front_end_tb;

    localparam int NUM_TESTS = 6;
    localparam int BP_TEST   = 5;

    // One fetch word with an optional flush once drain instructions came out
    typedef struct {
        int                  test;
        logic [`FE_XLEN-1:0] addr;
        logic [`FE_XLEN-1:0] word;
        int                  drain;
        bit                  no_gap;
    } stim_t;

    typedef struct {
        int                  test;
        logic [`FE_XLEN-1:0] instr;
        logic [`FE_XLEN-1:0] pc;
        logic                compressed;
        logic                illegal;
    } expect_t;

    logic                clk;
    logic                rst_n;
    logic                flush;
    logic                fetch_valid;
    logic [`FE_XLEN-1:0] fetch_word;
    logic [`FE_XLEN-1:0] fetch_addr;
    logic                fetch_ready;
    logic                instr_valid;
    logic                instr_compressed;
    logic                illegal;
    logic [`FE_XLEN-1:0] instr;
    logic [`FE_XLEN-1:0] instr_pc;

    stim_t   stim_q[$];
    expect_t exp_q[$];
    string   test_name [NUM_TESTS] = '{"wide_only", "two_rvc", "cross_word",
                                       "illegal_rvc", "flush", "back_pressure"};
    bit      stalled [NUM_TESTS];
    bit      table_ready = 1'b0;
    int      n_seen      = 0;
    int      err_value   = 0;
    int      err_extra   = 0;
    int      err_other   = 0;

    tb_clock_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (10)
    ) u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    front_end_top DUT (
        .clk_i              (clk),
        .rst_n_i            (rst_n),
        .flush_i            (flush),
        .fetch_valid_i      (fetch_valid),
        .fetch_word_i       (fetch_word),
        .fetch_addr_i       (fetch_addr),
        .fetch_ready_o      (fetch_ready),
        .instr_valid_o      (instr_valid),
        .instr_compressed_o (instr_compressed),
        .illegal_o          (illegal),
        .instr_o            (instr),
        .instr_pc_o         (instr_pc)
    );

    //======================================================================
    // Instruction encoders and table
    //======================================================================

    function automatic logic [15:0] ci_parcel(input logic [2:0] f3, input int rd, input int imm);
        logic [5:0] i6;
        i6 = imm[5:0];
        return {f3, i6[5], rd[4:0], i6[4:0], 2'b01};
    endfunction

    function automatic logic [15:0] cr_parcel(input logic [3:0] f4, input int rd, input int rs2);
        return {f4, rd[4:0], rs2[4:0], 2'b10};
    endfunction

    function automatic logic [31:0] addi_instr(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] add_instr(input int rd, input int rs1, input int rs2);
        return {7'b0, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
    endfunction

    task automatic queue_word(input int t, input logic [31:0] a, input logic [31:0] w,
                              input int drain, input bit no_gap);
        stim_t s;
        s.test   = t;
        s.addr   = a;
        s.word   = w;
        s.drain  = drain;
        s.no_gap = no_gap;
        stim_q.push_back(s);
    endtask

    task automatic expect_instr(input int t, input logic [31:0] i, input logic [31:0] pc,
                                input logic c, input logic ill);
        expect_t e;
        e.test       = t;
        e.instr      = i;
        e.pc         = pc;
        e.compressed = c;
        e.illegal    = ill;
        exp_q.push_back(e);
    endtask

    task automatic build_table();
        logic [`FE_XLEN-1:0] wide;
        int                  k;
        for (k = 0; k < 3; k++) begin
            wide = (k == 1) ? add_instr(3, 1, 2) : addi_instr(k + 1, 1, k - 1);
            queue_word(0, 32'h100 + 4 * k, wide, -1, 1'b0);
            expect_instr(0, wide, 32'h100 + 4 * k, 1'b0, 1'b0);
        end
        // C.ADDI x4,7 in the low half and C.LI x5,-3 in the high half
        queue_word(1, 32'h200, {ci_parcel(3'b010, 5, -3), ci_parcel(3'b000, 4, 7)}, -1, 1'b0);
        expect_instr(1, addi_instr(4, 4, 7), 32'h200, 1'b1, 1'b0);
        expect_instr(1, addi_instr(5, 0, -3), 32'h202, 1'b1, 1'b0);
        // C.MV, then a 32-bit ADDI split across two words, then C.ADD
        wide = addi_instr(10, 11, 'h123);
        queue_word(2, 32'h300, {wide[15:0], cr_parcel(4'b1000, 6, 7)}, -1, 1'b0);
        queue_word(2, 32'h304, {cr_parcel(4'b1001, 8, 9), wide[31:16]}, -1, 1'b0);
        expect_instr(2, add_instr(6, 0, 7), 32'h300, 1'b1, 1'b0);
        expect_instr(2, wide, 32'h302, 1'b0, 1'b0);
        expect_instr(2, add_instr(8, 8, 9), 32'h306, 1'b1, 1'b0);
        // Quadrant 0 zero parcel and C.MV with rs2 = x0
        queue_word(3, 32'h400, {cr_parcel(4'b1000, 3, 0), 16'h0000}, -1, 1'b0);
        expect_instr(3, `FE_NOP, 32'h400, 1'b1, 1'b1);
        expect_instr(3, `FE_NOP, 32'h402, 1'b1, 1'b1);
        // The upper half starts a 32-bit instruction that the flush must discard
        wide = addi_instr(1, 1, 1);
        queue_word(4, 32'h500, {wide[15:0], ci_parcel(3'b010, 2, 1)}, -1, 1'b0);
        expect_instr(4, addi_instr(2, 0, 1), 32'h500, 1'b1, 1'b0);
        queue_word(4, 32'h600, addi_instr(7, 0, 9), exp_q.size(), 1'b0);
        expect_instr(4, addi_instr(7, 0, 9), 32'h600, 1'b0, 1'b0);
        for (k = 0; k < 10; k++) begin
            queue_word(BP_TEST, 32'h700 + 4 * k,
                       {ci_parcel(3'b000, k + 1, k), ci_parcel(3'b010, k + 1, k + 8)}, -1, 1'b1);
            expect_instr(BP_TEST, addi_instr(k + 1, 0, k + 8), 32'h700 + 4 * k, 1'b1, 1'b0);
            expect_instr(BP_TEST, addi_instr(k + 1, k + 1, k), 32'h702 + 4 * k, 1'b1, 1'b0);
        end
    endtask

    //======================================================================
    // Checker, driver and watchdog
    //======================================================================

    // Outputs change on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        expect_t want;
        if (rst_n && instr_valid) begin
            if (n_seen >= exp_q.size()) begin
                $display("Error: extra instruction strobe, instr %h at pc %h", instr, instr_pc);
                err_extra++;
            end else begin
                want = exp_q[n_seen];
                if ({instr, instr_pc, instr_compressed, illegal} !==
                    {want.instr, want.pc, want.compressed, want.illegal}) begin
                    $display("Fail %s: expected %h pc %h c %0b ill %0b, actual %h pc %h c %0b ill %0b",
                             test_name[want.test], want.instr, want.pc, want.compressed,
                             want.illegal, instr, instr_pc, instr_compressed, illegal);
                    err_value++;
                end
                n_seen++;
            end
        end
    end

    initial begin
        int gap;
        flush       = 1'b0;
        fetch_valid = 1'b0;
        fetch_word  = '0;
        fetch_addr  = '0;
        void'($urandom(32'h6df2_244d));
        build_table();
        table_ready = 1'b1;
        wait (rst_n);
        @(negedge clk);
        foreach (stim_q[i]) begin
            if (stim_q[i].drain >= 0) begin
                while (n_seen < stim_q[i].drain) @(negedge clk);
                repeat (2) @(negedge clk);
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
            end
            fetch_valid = 1'b1;
            fetch_word  = stim_q[i].word;
            fetch_addr  = stim_q[i].addr;
            // Ready seen at a falling edge holds through the next rising edge
            while (!fetch_ready) begin
                stalled[stim_q[i].test] = 1'b1;
                @(negedge clk);
            end
            @(negedge clk);
            fetch_valid = 1'b0;
            if (!stim_q[i].no_gap) begin
                gap = $urandom_range(2, 0);
                repeat (gap) @(negedge clk);
            end
        end
        while (n_seen < exp_q.size()) @(negedge clk);
        repeat (20) @(negedge clk);
        if (!stalled[BP_TEST]) begin
            $display("Error: fetch_ready_o never fell during the back-pressure stream");
            err_other++;
        end
        $display("Summary: %0d wrong values, %0d extra strobes, %0d other errors",
                 err_value, err_extra, err_other);
        if (err_value + err_extra + err_other == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        int limit;
        wait (table_ready);
        limit = stim_q.size() * 60 + 10;
        repeat (limit) @(posedge clk);
        $display("Timeout: only %0d of %0d expected instructions arrived within %0d cycles",
                 n_seen, exp_q.size(), limit);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule : front_end_tb

/* verif/front_end_props.sv */
`timescale 1ns/1ps

`include "fe_config.svh"

module front_end_props (
    input logic                clk_i,
    input logic                rst_n_i,
    input logic                flush_i,
    input logic                valid_i,
    input logic                compressed_i,
    input logic                illegal_i,
    input logic [`FE_XLEN-1:0] pc_i
);

    // Flags only carry meaning together with the strobe
    flags_need_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (illegal_i || compressed_i) |-> valid_i)
        else $error("illegal or compressed flag raised without instr_valid_o");

    // Every instruction starts on a half-word boundary
    pc_half_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i |-> !pc_i[0])
        else $error("instr_pc_o is odd while instr_valid_o is high");

    flush_kills_output: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> !valid_i)
        else $error("instr_valid_o high in the cycle after a flush");

    reset_quiet: assert property (@(posedge clk_i) !rst_n_i |=> !valid_i)
        else $error("instr_valid_o high while reset is held");

endmodule : front_end_props

bind front_end_top front_end_props u_front_end_props (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .valid_i      (instr_valid_o),
    .compressed_i (instr_compressed_o),
    .illegal_i    (illegal_o),
    .pc_i         (instr_pc_o)
);

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        // Reset lets go on a falling edge in step with the other DUT inputs
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule : tb_clock_gen

/* source/front_end_top.sv */
`timescale 1ns/1ps

`include "fe_config.svh"

module front_end_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                fetch_valid_i,
    input  logic [`FE_XLEN-1:0] fetch_word_i,
    input  logic [`FE_XLEN-1:0] fetch_addr_i,
    output logic                fetch_ready_o,
    output logic                instr_valid_o,
    output logic                instr_compressed_o,
    output logic                illegal_o,
    output logic [`FE_XLEN-1:0] instr_o,
    output logic [`FE_XLEN-1:0] instr_pc_o
);

    fetch_if buf_if ();

    fe_pkg::fetch_entry_t wr_entry;
    logic                 buf_full;
    rv_isa_pkg::half_t    rvc_half;
    logic [`FE_XLEN-1:0]  rvc_instr;
    logic                 rvc_illegal;

    assign wr_entry      = '{addr: fetch_addr_i, word: fetch_word_i};
    assign fetch_ready_o = !buf_full;

    // A word offered in the flush cycle is dropped with the rest
    fetch_buffer #(
        .DEPTH (`FE_IBUF_DEPTH)
    ) u_fetch_buffer (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .wr_en_i    (fetch_valid_i && !flush_i),
        .wr_entry_i (wr_entry),
        .full_o     (buf_full),
        .buf_if     (buf_if)
    );

    instr_aligner u_instr_aligner (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .flush_i            (flush_i),
        .buf_if             (buf_if),
        .rvc_half_o         (rvc_half),
        .rvc_instr_i        (rvc_instr),
        .rvc_illegal_i      (rvc_illegal),
        .instr_valid_o      (instr_valid_o),
        .instr_compressed_o (instr_compressed_o),
        .illegal_o          (illegal_o),
        .instr_o            (instr_o),
        .instr_pc_o         (instr_pc_o)
    );

    rvc_expander u_rvc_expander (
        .half_i    (rvc_half),
        .instr_o   (rvc_instr),
        .illegal_o (rvc_illegal)
    );

endmodule : front_end_top

/* source/instr_aligner.sv */
`timescale 1ns/1ps

`include "fe_config.svh"

module instr_aligner (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    fetch_if.consumer           buf_if,
    output rv_isa_pkg::half_t   rvc_half_o,
    input  logic [`FE_XLEN-1:0] rvc_instr_i,
    input  logic                rvc_illegal_i,
    output logic                instr_valid_o,
    output logic                instr_compressed_o,
    output logic                illegal_o,
    output logic [`FE_XLEN-1:0] instr_o,
    output logic [`FE_XLEN-1:0] instr_pc_o
);

    fe_pkg::fetch_entry_t  head;
    fe_pkg::pending_half_t pend_q;
    fe_pkg::pending_half_t pend_d;
    fe_pkg::pending_half_t upper_save;

    logic                pend_rvc;
    logic                head_rvc;
    logic                emit;
    logic                is_rvc;
    logic                rd_en;
    logic [`FE_XLEN-1:0] nxt_instr;
    logic [`FE_XLEN-1:0] nxt_pc;

    assign head = buf_if.head;

    // A parcel is compressed unless its two low bits are both set
    assign pend_rvc = (pend_q.half[1:0] != 2'b11);
    assign head_rvc = (head.word[1:0] != 2'b11);

    // What remains of the head word once its lower half is consumed
    assign upper_save = '{present: 1'b1, addr: head.addr + 'd2, half: head.word[31:16]};

    // The expander always sees the parcel that starts the next instruction
    assign rvc_half_o  = pend_q.present ? pend_q.half : head.word[15:0];
    assign buf_if.read = rd_en;

    //======================================================================
    // Alignment decision
    //======================================================================

    always_comb begin
        emit      = 1'b0;
        is_rvc    = 1'b0;
        rd_en     = 1'b0;
        nxt_instr = head.word;
        nxt_pc    = head.addr;
        pend_d    = pend_q;

        if (!flush_i) begin
            if (pend_q.present && pend_rvc) begin
                // Saved compressed parcel goes out on its own without a new word
                emit           = 1'b1;
                is_rvc         = 1'b1;
                nxt_instr      = rvc_instr_i;
                nxt_pc         = pend_q.addr;
                pend_d.present = 1'b0;
            end else if (pend_q.present && !buf_if.empty) begin
                // Instruction crosses the word boundary
                emit      = 1'b1;
                rd_en     = 1'b1;
                nxt_instr = {head.word[15:0], pend_q.half};
                nxt_pc    = pend_q.addr;
                pend_d    = upper_save;
            end else if (!pend_q.present && !buf_if.empty) begin
                emit  = 1'b1;
                rd_en = 1'b1;
                if (head_rvc) begin
                    is_rvc    = 1'b1;
                    nxt_instr = rvc_instr_i;
                    pend_d    = upper_save;
                end
            end
        end
    end

    //======================================================================
    // Saved half and output stage
    //======================================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pend_q             <= '0;
            instr_valid_o      <= 1'b0;
            instr_compressed_o <= 1'b0;
            illegal_o          <= 1'b0;
            instr_o            <= `FE_NOP;
            instr_pc_o         <= '0;
        end else if (flush_i) begin
            pend_q.present     <= 1'b0;
            instr_valid_o      <= 1'b0;
            instr_compressed_o <= 1'b0;
            illegal_o          <= 1'b0;
        end else begin
            pend_q             <= pend_d;
            instr_valid_o      <= emit;
            instr_compressed_o <= emit && is_rvc;
            illegal_o          <= emit && is_rvc && rvc_illegal_i;
            if (emit) begin
                instr_o    <= nxt_instr;
                instr_pc_o <= nxt_pc;
            end
        end
    end

endmodule : instr_aligner

/* source/rvc_expander.sv */
`timescale 1ns/1ps

`include "fe_config.svh"

module rvc_expander (
    input  rv_isa_pkg::half_t   half_i,
    output logic [`FE_XLEN-1:0] instr_o,
    output logic                illegal_o
);

    rv_isa_pkg::rvc_word_u cw;
    logic [11:0]           imm12;

    assign cw = half_i;

    // Six-bit CI immediate sign-extended from bit 12 of the parcel
    assign imm12 = {{6{cw.ci.imm5}}, cw.ci.imm5, cw.ci.imm4_0};

    always_comb begin
        instr_o   = `FE_NOP;
        illegal_o = 1'b1;

        if (cw.ci.op == rv_isa_pkg::RVC_Q1) begin
            case (cw.ci.funct3)
                rv_isa_pkg::RVC_F3_ADDI: begin
                    // rd = 0 with a zero immediate is C.NOP and lands on the same NOP
                    instr_o   = {imm12, cw.ci.rd, 3'b000, cw.ci.rd, rv_isa_pkg::OPC_OP_IMM};
                    illegal_o = 1'b0;
                end
                rv_isa_pkg::RVC_F3_LI: begin
                    instr_o   = {imm12, 5'd0, 3'b000, cw.ci.rd, rv_isa_pkg::OPC_OP_IMM};
                    illegal_o = 1'b0;
                end
                default: begin
                    instr_o   = `FE_NOP;
                    illegal_o = 1'b1;
                end
            endcase
        end else if (cw.cr.op == rv_isa_pkg::RVC_Q2 && cw.cr.rs2 != 5'd0) begin
            // With rs2 = 0 these encodings are C.JR, C.JALR or C.EBREAK
            case (cw.cr.funct4)
                rv_isa_pkg::RVC_F4_MV: begin
                    instr_o   = {7'b0, cw.cr.rs2, 5'd0, 3'b000, cw.cr.rd, rv_isa_pkg::OPC_OP};
                    illegal_o = 1'b0;
                end
                rv_isa_pkg::RVC_F4_ADD: begin
                    instr_o   = {7'b0, cw.cr.rs2, cw.cr.rd, 3'b000, cw.cr.rd, rv_isa_pkg::OPC_OP};
                    illegal_o = 1'b0;
                end
                default: begin
                    instr_o   = `FE_NOP;
                    illegal_o = 1'b1;
                end
            endcase
        end
    end

endmodule : rvc_expander

/* source/fetch_buffer.sv */
`timescale 1ns/1ps

`include "fe_config.svh"

module fetch_buffer #(
    parameter int DEPTH = `FE_IBUF_DEPTH
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,
    input  logic                 wr_en_i,
    input  fe_pkg::fetch_entry_t wr_entry_i,
    output logic                 full_o,
    fetch_if.provider            buf_if
);

    localparam int PTR_W = $clog2(DEPTH);

    fe_pkg::fetch_entry_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wr_en_i && !full_o;
    assign do_rd = buf_if.read && !buf_if.empty;

    assign full_o       = (count == (PTR_W+1)'(DEPTH));
    assign buf_if.empty = (count == '0);
    assign buf_if.head  = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_entry_i;
        end
    end

    // Pointers wrap explicitly so that any depth works
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : fetch_buffer

/* source/fetch_if.sv */
`timescale 1ns/1ps

interface fetch_if;

    // Oldest buffered fetch word that stays valid while empty is low
    fe_pkg::fetch_entry_t head;
    logic                 empty;

    // Pops the head at the next rising edge
    logic                 read;

    modport provider (
        output head,
        output empty,
        input  read
    );

    modport consumer (
        input  head,
        input  empty,
        output read
    );

endinterface : fetch_if

/* source/fe_pkg.sv */
`include "fe_config.svh"

package fe_pkg;

    // A fetch word together with its word-aligned address
    typedef struct packed {
        logic [`FE_XLEN-1:0] addr;
        logic [`FE_XLEN-1:0] word;
    } fetch_entry_t;

    // Upper half of a word kept back for the next alignment decision
    typedef struct packed {
        logic                present;
        logic [`FE_XLEN-1:0] addr;
        rv_isa_pkg::half_t   half;
    } pending_half_t;

endpackage : fe_pkg

/* source/rv_isa_pkg.sv */
package rv_isa_pkg;

    // One 16-bit parcel of the instruction stream
    typedef logic [15:0] half_t;

    // Compressed immediate format, used by C.ADDI and C.LI
    typedef struct packed {
        logic [2:0] funct3;
        logic       imm5;
        logic [4:0] rd;
        logic [4:0] imm4_0;
        logic [1:0] op;
    } rvc_ci_t;

    // Compressed register format, used by C.MV and C.ADD
    typedef struct packed {
        logic [3:0] funct4;
        logic [4:0] rd;
        logic [4:0] rs2;
        logic [1:0] op;
    } rvc_cr_t;

    // The same parcel seen through either format
    typedef union packed {
        rvc_ci_t ci;
        rvc_cr_t cr;
    } rvc_word_u;

    // Compressed quadrants and the function codes decoded in them
    localparam logic [1:0] RVC_Q1     = 2'b01;
    localparam logic [1:0] RVC_Q2     = 2'b10;
    localparam logic [2:0] RVC_F3_ADDI = 3'b000;
    localparam logic [2:0] RVC_F3_LI   = 3'b010;
    localparam logic [3:0] RVC_F4_MV   = 4'b1000;
    localparam logic [3:0] RVC_F4_ADD  = 4'b1001;

    // Major opcodes of the 32-bit forms produced by expansion
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

endpackage : rv_isa_pkg

/* source/fe_config.svh */
`ifndef FE_CONFIG_SVH
`define FE_CONFIG_SVH

// Width of an instruction word and of a fetch address
`define FE_XLEN 32

// Number of fetch words the buffer holds by default
`define FE_IBUF_DEPTH 4

// ADDI x0,x0,0
`define FE_NOP 32'h0000_0013

`endif
